//--- files.f
common/motorPkg.sv
common/motorCtrlIf.sv
design/motorCmdLatch.sv
design/stepTimer.sv
design/commutator.sv
design/pwm/pwmGenerator.sv
design/gateDriver.sv
design/motorTop.sv
verification/motorTb.sv

//--- Makefile
TOP := motorTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/motorTb.sv
module motorTb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string name;
        logic [7:0] duty;
        logic [15:0] period;
        logic dir;
        int steps;
    } testRow;

    // expected gate pattern of each step with bit 0 for phase a.
    localparam logic [2:0] highSide [0:5] = '{3'b001, 3'b001, 3'b010, 3'b010, 3'b100, 3'b100};
    localparam logic [2:0] lowSide [0:5] = '{3'b010, 3'b100, 3'b100, 3'b001, 3'b001, 3'b010};
    localparam int windowStart = 16;
    localparam int rowCount = 8;

    logic clk = 1'b0;
    logic nRst = 1'b0;
    logic cmdValid = 1'b0;
    logic cmdReady;
    logic [7:0] cmdDuty = '0;
    logic [15:0] cmdPeriod = '0;
    logic cmdDir = 1'b0;
    logic cmdRun = 1'b0;
    logic [2:0] gateHigh;
    logic [2:0] gateLow;

    testRow rows [0:rowCount-1];
    testRow bpRow;
    int seed = 32'hbc24;
    int budget = 0;
    int cycle = 0;
    int checkCount = 0;
    int errorCount = 0;
    int startA;
    int startB;

    motorTop u_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAIL %s: expected %0d, got %0d at %0t", name, expected, actual, $time);
        end
    endtask

    // full duty keeps the high side on for the whole frame.
    function automatic int expectedHighCycles(input logic [7:0] duty);
        return (duty == 8'hff) ? 256 : int'(duty);
    endfunction

    function automatic logic [2:0] nextStep(input logic [2:0] idx, input logic dir);
        if (dir) begin
            return (idx == 3'd0) ? 3'd5 : idx - 3'd1;
        end
        return (idx == 3'd5) ? 3'd0 : idx + 3'd1;
    endfunction

    // returns on the falling edge right after the command is applied.
    task automatic sendCmd(input string name, input logic [7:0] duty, input logic [15:0] period,
                           input logic dir, input logic run);
        int waited;
        @(negedge clk);
        cmdDuty = duty;
        cmdPeriod = period;
        cmdDir = dir;
        cmdRun = run;
        cmdValid = 1'b1;
        waited = 0;
        while (!cmdReady && waited < 4096) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        cmdValid = 1'b0;
        checkValue({name, " ready after transfer"}, 0, 32'(cmdReady));
        waited = 0;
        while (!cmdReady && waited < 4096) begin
            @(negedge clk);
            waited++;
        end
        if (!cmdReady) begin
            $display("ERROR %s: the command was never accepted or applied", name);
            errorCount++;
        end
    endtask

    task automatic runSteps(input testRow row, input logic [2:0] firstStep, input logic fromStop);
        logic [2:0] idx;
        logic [2:0] prevHigh;
        logic [2:0] prevLow;
        logic [2:0] changed;
        int period;
        int count;
        idx = firstStep;
        period = int'(row.period);
        prevHigh = fromStop ? 3'b000 : highSide[nextStep(idx, !row.dir)];
        prevLow = fromStop ? 3'b000 : lowSide[nextStep(idx, !row.dir)];
        for (int n = 0; n < row.steps; n++) begin
            changed = (prevHigh ^ highSide[idx]) | (prevLow ^ lowSide[idx]);
            count = 0;
            for (int k = 0; k < period; k++) begin
                checkValue({row.name, " overlap"}, 0, 32'(gateHigh & gateLow));
                if (k >= 1 && k <= motorPkg::deadTime) begin
                    checkValue({row.name, " dead time"}, 0, 32'((gateHigh | gateLow) & changed));
                end
                if (k == period / 2) begin
                    checkValue({row.name, " gateLow"}, 32'(lowSide[idx]), 32'(gateLow));
                    if (row.duty == 8'hff) begin
                        checkValue({row.name, " gateHigh"}, 32'(highSide[idx]), 32'(gateHigh));
                    end else begin
                        checkValue({row.name, " gateHigh"}, 0, 32'(gateHigh & ~highSide[idx]));
                    end
                end
                if (k >= windowStart && k < windowStart + 256 && |(gateHigh & highSide[idx])) begin
                    count++;
                end
                @(negedge clk);
            end
            if (period >= windowStart + 256) begin
                checkValue({row.name, " duty"}, expectedHighCycles(row.duty), count);
            end
            prevHigh = highSide[idx];
            prevLow = lowSide[idx];
            idx = nextStep(idx, row.dir);
        end
    endtask

    initial begin
        rows[0] = '{"forward", 8'd255, 16'd64, 1'b0, 7};
        rows[1] = '{"reverse", 8'd255, 16'd64, 1'b1, 7};
        rows[2] = '{"dutyZero", 8'd0, 16'd1024, 1'b0, 1};
        rows[3] = '{"dutyFull", 8'd255, 16'd1024, 1'b0, 1};
        rows[4] = '{"dutyMid", 8'd100, 16'd1024, 1'b0, 2};
        rows[5] = '{"dutyOne", 8'd1, 16'd1024, 1'b1, 2};
        rows[6] = '{"dutyRandA", 8'($random(seed)), 16'd1024, 1'b0, 1};
        rows[7] = '{"dutyRandB", 8'($random(seed)), 16'd1024, 1'b1, 2};
        bpRow = '{"backPressure", 8'd192, 16'd1024, 1'b0, 1};
        budget = 4 * 1024 + 100;
        foreach (rows[i]) begin
            budget += int'(rows[i].period) * (rows[i].steps + 2);
        end
        budget = budget * 4 + 1000;
        repeat (10) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        checkValue("reset cmdReady", 1, 32'(cmdReady));
        checkValue("reset gateHigh", 0, 32'(gateHigh));
        checkValue("reset gateLow", 0, 32'(gateLow));
        foreach (rows[i]) begin
            sendCmd(rows[i].name, rows[i].duty, rows[i].period, rows[i].dir, 1'b1);
            runSteps(rows[i], 3'd0, 1'b1);
            sendCmd("stop", 8'd0, rows[i].period, 1'b0, 1'b0);
        end
        // the second command waits for the end of step 0.
        sendCmd("backPressure first", 8'd64, 16'd1024, 1'b0, 1'b1);
        startA = cycle;
        repeat (100) @(negedge clk);
        sendCmd("backPressure second", 8'd192, 16'd1024, 1'b0, 1'b1);
        startB = cycle;
        checkValue("backPressure boundary", 1024, 32'(startB - startA));
        runSteps(bpRow, 3'd1, 1'b0);
        sendCmd("stop", 8'd0, 16'd1024, 1'b0, 1'b0);
        $display("checks: %0d  errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (budget > 0);
        #(budget);
        $display("ERROR: timeout, the run did not finish within %0d ns", budget);
        $display("checks: %0d  errors: %0d", checkCount, errorCount + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- design/motorTop.sv
module motorTop (
    input  logic clk,
    input  logic nRst,
    input  logic cmdValid,
    output logic cmdReady,
    input  logic [motorPkg::dutyWidth-1:0] cmdDuty,
    input  logic [motorPkg::periodWidth-1:0] cmdPeriod,
    input  logic cmdDir,
    input  logic cmdRun,
    output logic [2:0] gateHigh,
    output logic [2:0] gateLow
);

    motorPkg::phaseState phase [0:2];
    logic pwm;

    // applied settings shared by the timing blocks.
    motorCtrlIf ctrlBus ();

    motorCmdLatch uCmdLatch (
        .clk(clk),
        .nRst(nRst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdDuty(cmdDuty),
        .cmdPeriod(cmdPeriod),
        .cmdDir(cmdDir),
        .cmdRun(cmdRun),
        .ctrl(ctrlBus.latchSide)
    );

    stepTimer uStepTimer (
        .clk(clk),
        .nRst(nRst),
        .ctrl(ctrlBus.timerSide)
    );

    commutator uCommutator (
        .clk(clk),
        .nRst(nRst),
        .ctrl(ctrlBus.userSide),
        .phase(phase)
    );

    pwmGenerator uPwmGenerator (
        .clk(clk),
        .nRst(nRst),
        .ctrl(ctrlBus.userSide),
        .pwm(pwm)
    );

    gateDriver uGateDriver (
        .clk(clk),
        .nRst(nRst),
        .phase(phase),
        .pwm(pwm),
        .gateHigh(gateHigh),
        .gateLow(gateLow)
    );

endmodule

//--- design/gateDriver.sv
module gateDriver (
    input  logic clk,
    input  logic nRst,
    input  motorPkg::phaseState phase [0:2],
    input  logic pwm,
    output logic [2:0] gateHigh,
    output logic [2:0] gateLow
);

    localparam logic [motorPkg::deadWidth-1:0] deadLoad =
        motorPkg::deadWidth'(motorPkg::deadTime - 1);

    motorPkg::phaseState prevPhase [0:2];
    logic [motorPkg::deadWidth-1:0] deadCnt [0:2];

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < 3; i++) begin
                prevPhase[i] <= motorPkg::phaseFloat;
                deadCnt[i] <= '0;
            end
            gateHigh <= '0;
            gateLow <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                prevPhase[i] <= phase[i];
                if (phase[i] != prevPhase[i]) begin
                    // both gates off right away, then for the dead time.
                    deadCnt[i] <= deadLoad;
                    gateHigh[i] <= 1'b0;
                    gateLow[i] <= 1'b0;
                end else begin
                    if (deadCnt[i] != '0) begin
                        deadCnt[i] <= deadCnt[i] - 1'b1;
                    end
                    gateHigh[i] <= (deadCnt[i] == '0) && pwm &&
                                   (phase[i] == motorPkg::phaseHigh);
                    gateLow[i] <= (deadCnt[i] == '0) &&
                                  (phase[i] == motorPkg::phaseLow);
                end
            end
        end
    end

endmodule

//--- design/pwm/pwmGenerator.sv
module pwmGenerator (
    input  logic clk,
    input  logic nRst,
    motorCtrlIf.userSide ctrl,
    output logic pwm
);

    logic [motorPkg::dutyWidth-1:0] dutyReg;
    logic [motorPkg::dutyWidth-1:0] cnt;
    logic reloadReq;
    logic reload;
    logic fullDuty;
    logic zeroDuty;

    // the command latch updates duty on the boundary edge itself,
    // so the new value is picked up in the first cycle of the step.
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            reloadReq <= 1'b1;
        end else begin
            reloadReq <= ctrl.stepLast || !ctrl.run;
        end
    end

    assign reload = ctrl.run && reloadReq;
    assign fullDuty = (dutyReg == motorPkg::dutyWidth'(motorPkg::maxDuty));
    assign zeroDuty = (dutyReg == '0);

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            dutyReg <= '0;
            cnt <= '0;
            pwm <= 1'b0;
        end else if (!ctrl.run) begin
            cnt <= '0;
            pwm <= 1'b0;
        end else if (reload) begin
            // restart the frame with the on-time.
            dutyReg <= ctrl.duty;
            if (ctrl.duty == '0) begin
                pwm <= 1'b0;
                cnt <= '0;
            end else begin
                pwm <= 1'b1;
                cnt <= ctrl.duty - 1'b1;
            end
        end else if (fullDuty) begin
            pwm <= 1'b1;
        end else if (zeroDuty) begin
            pwm <= 1'b0;
        end else if (cnt == '0) begin
            pwm <= !pwm;
            // off-time is the complement of the duty.
            if (pwm) begin
                cnt <= ~dutyReg;
            end else begin
                cnt <= dutyReg - 1'b1;
            end
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- design/commutator.sv
module commutator (
    input  logic clk,
    input  logic nRst,
    motorCtrlIf.userSide ctrl,
    output motorPkg::phaseState phase [0:2]
);

    localparam logic [motorPkg::stepWidth-1:0] lastStep =
        motorPkg::stepWidth'(motorPkg::stepCount - 1);

    logic [motorPkg::stepWidth-1:0] stepIdx;
    logic [motorPkg::stepWidth-1:0] nextFwd;
    logic [motorPkg::stepWidth-1:0] nextRev;

    // wrap around the six steps in both directions.
    assign nextFwd = (stepIdx == lastStep) ? '0 : stepIdx + 1'b1;
    assign nextRev = (stepIdx == '0) ? lastStep : stepIdx - 1'b1;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            stepIdx <= '0;
        end else if (!ctrl.run) begin
            stepIdx <= '0;
        end else if (ctrl.stepLast) begin
            if (ctrl.dir) begin
                stepIdx <= nextRev;
            end else begin
                stepIdx <= nextFwd;
            end
        end
    end

    // all phases float while stopped.
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (ctrl.run) begin
                phase[i] = motorPkg::stepTable[stepIdx][i];
            end else begin
                phase[i] = motorPkg::phaseFloat;
            end
        end
    end

endmodule

//--- design/stepTimer.sv
module stepTimer (
    input  logic clk,
    input  logic nRst,
    motorCtrlIf.timerSide ctrl
);

    logic [motorPkg::periodWidth-1:0] count;
    logic [motorPkg::periodWidth-1:0] lastCount;
    logic atLast;

    assign lastCount = ctrl.period - 1'b1;
    assign atLast = (count == lastCount);

    // a step lasts exactly period cycles.
    assign ctrl.stepLast = ctrl.run && atLast;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            count <= '0;
        end else if (!ctrl.run) begin
            count <= '0;
        end else if (atLast) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- design/motorCmdLatch.sv
module motorCmdLatch (
    input  logic clk,
    input  logic nRst,
    input  logic cmdValid,
    output logic cmdReady,
    input  logic [motorPkg::dutyWidth-1:0] cmdDuty,
    input  logic [motorPkg::periodWidth-1:0] cmdPeriod,
    input  logic cmdDir,
    input  logic cmdRun,
    motorCtrlIf.latchSide ctrl
);

    logic pending;
    logic [motorPkg::dutyWidth-1:0] pendDuty;
    logic [motorPkg::periodWidth-1:0] pendPeriod;
    logic pendDir;
    logic pendRun;
    logic applyNow;

    // one command may wait at a time.
    assign cmdReady = !pending;

    // a stopped motor has no step boundary to wait for.
    assign applyNow = pending && (ctrl.stepLast || !ctrl.run);

    always_ff @(posedge clk) begin
        if (cmdValid && cmdReady) begin
            pendDuty <= cmdDuty;
            pendPeriod <= cmdPeriod;
            pendDir <= cmdDir;
            pendRun <= cmdRun;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            pending <= 1'b0;
            ctrl.duty <= '0;
            ctrl.period <= '0;
            ctrl.dir <= 1'b0;
            ctrl.run <= 1'b0;
        end else if (applyNow) begin
            pending <= 1'b0;
            ctrl.duty <= pendDuty;
            ctrl.period <= pendPeriod;
            ctrl.dir <= pendDir;
            ctrl.run <= pendRun;
        end else if (cmdValid && cmdReady) begin
            pending <= 1'b1;
        end
    end

endmodule

//--- common/motorCtrlIf.sv
interface motorCtrlIf;

    logic [motorPkg::dutyWidth-1:0] duty;
    logic [motorPkg::periodWidth-1:0] period;
    logic dir;
    logic run;

    // high in the last cycle of a commutation step.
    logic stepLast;

    modport latchSide (
        output duty, period, dir, run,
        input stepLast
    );

    modport timerSide (
        input period, run,
        output stepLast
    );

    modport userSide (
        input duty, period, dir, run, stepLast
    );

endinterface

//--- common/motorPkg.sv
package motorPkg;

    // widths of the command fields.
    localparam int dutyWidth = 8;
    localparam int periodWidth = 16;

    // full duty keeps the high side on for the whole frame.
    localparam int maxDuty = (1 << dutyWidth) - 1;

    // cycles both gates of a phase stay off after a state change.
    localparam int deadTime = 4;
    localparam int deadWidth = $clog2(deadTime + 1);

    localparam int stepCount = 6;
    localparam int stepWidth = 3;

    typedef enum logic [1:0] {
        phaseFloat = 2'd0,
        phaseHigh = 2'd1,
        phaseLow = 2'd2
    } phaseState;

    // six-step pattern, one row per step, columns are phases a, b, c.
    localparam phaseState stepTable [0:stepCount-1][0:2] = '{
        '{phaseHigh, phaseLow, phaseFloat},
        '{phaseHigh, phaseFloat, phaseLow},
        '{phaseFloat, phaseHigh, phaseLow},
        '{phaseLow, phaseHigh, phaseFloat},
        '{phaseLow, phaseFloat, phaseHigh},
        '{phaseFloat, phaseLow, phaseHigh}
    };

endpackage
